// File: filelist.f
hw/load_cfg_pkg.sv
hw/load_types_pkg.sv
hw/load_req_decode.sv
hw/load_ctrl_fsm.sv
hw/load_meta_fifo.sv
hw/load_result_align.sv
hw/load_unit_top.sv
sim/tb_clk_gen.sv
sim/tb_load_unit.sv

// File: Bender.yml
package:
  name: load_unit

sources:
  - hw/load_cfg_pkg.sv
  - hw/load_types_pkg.sv
  - hw/load_req_decode.sv
  - hw/load_ctrl_fsm.sv
  - hw/load_meta_fifo.sv
  - hw/load_result_align.sv
  - hw/load_unit_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_load_unit.sv

// File: sim/tb_load_unit.sv
// --------------------------------------
// load unit testbench with a cache and TLB model
// inputs change 1 ns after the rising edge and outputs are sampled at the
// falling edge, all from one process so no event order matters
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_load_unit;

    import load_cfg_pkg::*;
    import load_types_pkg::*;

    typedef struct {
        load_op_e                 op;
        logic [VLEN-1:0]          vaddr;
        logic [XLEN-1:0]          data;
        int unsigned              gnt_delay;
        int unsigned              tlb_misses;
        int unsigned              hazard_cycles;
        bit                       flush;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } stim_row_t;

    logic clk, rst_n, flush, valid, pop_ld, translation_req, dtlb_hit;
    logic page_offset_matches, valid_out;
    lsu_req_t lsu_req;
    logic [VLEN-1:0] vaddr;
    logic [PLEN-1:0] paddr;
    logic [INDEX_WIDTH-1:0] page_offset;
    dcache_req_t dcache_req;
    dcache_rsp_t dcache_rsp;
    logic [TRANS_ID_BITS-1:0] trans_id_out;
    logic [XLEN-1:0] result_out;

    // stimulus table and the cache memory, one word per index
    stim_row_t rows[$];
    bit table_ready = 1'b0;
    logic [XLEN-1:0] mem [2**INDEX_WIDTH];
    logic [31:0] lfsr = 32'h9121_4d37;

    // cache and TLB model state
    int unsigned gnt_cnt, gnt_delay, miss_left;
    bit exp_tag, exp_kill, prev_waiting, accepted, tlb_retry;
    logic [TAG_WIDTH-1:0] exp_tag_val;
    logic [XLEN-1:0] grant_word, next_rdata;
    logic next_rvalid;
    logic [XLEN-1:0] rsp_word[$];
    int rsp_due[$];
    int last_due, cyc, in_flight, max_in_flight, error_count;
    logic [TRANS_ID_BITS-1:0] exp_id[$];
    logic [XLEN-1:0] exp_result[$];

    tb_clk_gen i_tb_clk_gen (.clk_o(clk), .rst_no(rst_n));

    load_unit_top i_load_unit_top (
        .clk_i (clk), .rst_ni (rst_n), .flush_i (flush),
        .valid_i (valid), .lsu_req_i (lsu_req), .pop_ld_o (pop_ld),
        .translation_req_o (translation_req), .vaddr_o (vaddr),
        .dtlb_hit_i (dtlb_hit), .paddr_i (paddr),
        .page_offset_o (page_offset), .page_offset_matches_i (page_offset_matches),
        .dcache_req_o (dcache_req), .dcache_rsp_i (dcache_rsp),
        .valid_o (valid_out), .trans_id_o (trans_id_out), .result_o (result_out)
    );

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], next_random_bit()};
        end
        return r;
    endfunction

    function automatic int op_bytes(input load_op_e op);
        case (op)
            LB, LBU: return 1;
            LH, LHU: return 2;
            LW, LWU: return 4;
            default: return 8;
        endcase
    endfunction

    // shift the addressed bytes down, cut to width, then extend
    function automatic logic [XLEN-1:0] expected_result(input load_op_e op,
            input logic [2:0] off, input logic [XLEN-1:0] word);
        logic [XLEN-1:0] sh;
        sh = word >> (8 * off);
        case (op)
            LB:      return {{56{sh[7]}}, sh[7:0]};
            LBU:     return {56'h0, sh[7:0]};
            LH:      return {{48{sh[15]}}, sh[15:0]};
            LHU:     return {48'h0, sh[15:0]};
            LW:      return {{32{sh[31]}}, sh[31:0]};
            LWU:     return {32'h0, sh[31:0]};
            default: return sh;
        endcase
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] actual,
            input logic [XLEN-1:0] expected);
        if (actual !== expected) begin
            error_count++;
            stop_with_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
                $time, name, actual, expected));
        end
    endtask

    // the index low bits are the offset, the row number keeps indices apart
    task automatic add_row(input load_op_e op, input int off, input int unsigned gnt_d,
            input int unsigned misses, input int unsigned hazard, input bit fl);
        stim_row_t row;
        row.op            = op;
        row.vaddr         = {27'h2B3_C4D5, 9'(rows.size()), 3'(off)};
        row.data          = random_bits(64);
        row.gnt_delay     = gnt_d;
        row.tlb_misses    = misses;
        row.hazard_cycles = hazard;
        row.flush         = fl;
        row.trans_id      = TRANS_ID_BITS'(rows.size());
        rows.push_back(row);
    endtask

    task automatic build_table();
        load_op_e op;
        // every op at every aligned offset, all back to back
        for (int o = 0; o < 7; o++) begin
            op = load_op_e'(o);
            for (int off = 0; off < 8; off += op_bytes(op)) begin
                add_row(op, off, 0, 0, 0, 1'b0);
            end
        end
        add_row(LW, 4, 3, 0, 0, 1'b0);
        add_row(LH, 2, 0, 1, 0, 1'b0);
        add_row(LB, 5, 1, 2, 0, 1'b0);
        add_row(LD, 0, 0, 0, 3, 1'b0);
        // the flush row is killed while waiting for its grant
        add_row(LWU, 0, 5, 0, 0, 1'b1);
        add_row(LHU, 6, 0, 0, 0, 1'b0);
        add_row(LBU, 3, 2, 1, 2, 1'b0);
        add_row(LW, 0, 0, 0, 0, 1'b0);
    endtask

    // --------------------------------------
    // cache and TLB model, run at the falling edge
    // --------------------------------------
    task automatic model_eval();
        logic exp_pop;
        int delay;
        int due;
        exp_pop = dcache_req.data_req && dcache_rsp.data_gnt && dtlb_hit && !flush;
        check_value("pop_ld_o", pop_ld, exp_pop);

        // the virtual address goes out unchanged to the TLB and the hazard check
        check_value("vaddr_o", vaddr, lsu_req.vaddr);
        check_value("page_offset_o", page_offset, lsu_req.vaddr[INDEX_WIDTH-1:0]);
        // a cache request relies on the TLB answer of the same cycle
        if (dcache_req.data_req) begin
            check_value("translation_req_o", translation_req, 1'b1);
            check_value("dcache_req_o.index", dcache_req.index,
                lsu_req.vaddr[INDEX_WIDTH-1:0]);
            check_value("dcache_req_o.size in bytes", 64'(1) << dcache_req.size,
                op_bytes(lsu_req.op));
        end
        if (!valid && !flush) begin
            check_value("translation_req_o", translation_req, 1'b0);
        end

        if (page_offset_matches) begin
            check_value("data_req during offset hazard", dcache_req.data_req, 1'b0);
        end
        if (in_flight == META_DEPTH) begin
            check_value("data_req with queue full", dcache_req.data_req, 1'b0);
        end
        if (prev_waiting) begin
            check_value("data_req before grant", dcache_req.data_req, 1'b1);
        end

        // tag phase of the grant seen one cycle earlier
        if (exp_tag) begin
            check_value("tag_valid", dcache_req.tag_valid, 1'b1);
            check_value("kill_req", dcache_req.kill_req, 1'b0);
            check_value("tag", dcache_req.tag, exp_tag_val);
            delay = 1 + int'(random_bits(2) % 3);
            due = cyc + delay;
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            rsp_word.push_back(grant_word);
            rsp_due.push_back(due);
        end else if (exp_kill) begin
            check_value("tag_valid on kill", dcache_req.tag_valid, 1'b1);
            check_value("kill_req", dcache_req.kill_req, 1'b1);
        end else begin
            check_value("tag_valid", dcache_req.tag_valid, 1'b0);
        end
        exp_tag  = 1'b0;
        exp_kill = 1'b0;

        // retirement follows rvalid in the same cycle
        check_value("valid_o", valid_out, dcache_rsp.data_rvalid);
        if (dcache_rsp.data_rvalid) begin
            if (exp_id.size() == 0) begin
                stop_with_failure("valid_o was raised with no load outstanding");
            end
            check_value("trans_id_o", trans_id_out, exp_id.pop_front());
            check_value("result_o", result_out, exp_result.pop_front());
        end

        // a missed lookup counts when its grant is dropped or while the
        // unit waits for the translation after such a drop
        if (translation_req && !dtlb_hit) begin
            if (dcache_req.data_req ? dcache_rsp.data_gnt : tlb_retry) begin
                miss_left--;
            end
        end

        // grant bookkeeping
        prev_waiting = 1'b0;
        if (flush) begin
            exp_kill = 1'b1;
            gnt_cnt  = 0;
        end else if (dcache_req.data_req && dcache_rsp.data_gnt) begin
            gnt_cnt = 0;
            if (dtlb_hit) begin
                exp_tag     = 1'b1;
                exp_tag_val = paddr[PLEN-1:INDEX_WIDTH];
                grant_word  = mem[dcache_req.index];
            end else begin
                exp_kill  = 1'b1;
                tlb_retry = 1'b1;
            end
        end else if (dcache_req.data_req) begin
            gnt_cnt++;
            prev_waiting = 1'b1;
        end

        if (pop_ld) begin
            accepted = 1'b1;
        end
        in_flight = in_flight + int'(pop_ld) - int'(dcache_rsp.data_rvalid);
        if (in_flight > max_in_flight) begin
            max_in_flight = in_flight;
        end

        // response for the next cycle, in tag order
        next_rvalid = 1'b0;
        next_rdata  = '0;
        if (rsp_due.size() > 0 && rsp_due[0] <= cyc + 1) begin
            next_rvalid = 1'b1;
            next_rdata  = rsp_word.pop_front();
            void'(rsp_due.pop_front());
        end
        cyc++;
    endtask

    // one clock cycle, returns 1 ns after the next rising edge
    task automatic tick();
        dtlb_hit = (miss_left == 0);
        dcache_rsp.data_gnt = (gnt_cnt >= gnt_delay);
        @(negedge clk);
        model_eval();
        @(posedge clk);
        #1;
        dcache_rsp.data_rvalid = next_rvalid;
        dcache_rsp.data_rdata  = next_rdata;
    endtask

    task automatic apply_row(input stim_row_t row, input int r);
        logic [TAG_WIDTH-1:0] tag;
        tag = {5'(r), 12'h3C5, row.vaddr[VLEN-1:INDEX_WIDTH]};
        mem[row.vaddr[INDEX_WIDTH-1:0]] = row.data;
        miss_left = row.tlb_misses;
        tlb_retry = 1'b0;
        gnt_delay = row.gnt_delay;
        gnt_cnt   = 0;
        lsu_req.trans_id = row.trans_id;
        lsu_req.vaddr    = row.vaddr;
        lsu_req.op       = row.op;
        paddr = {tag, row.vaddr[INDEX_WIDTH-1:0]};
        valid = 1'b1;
        if (row.flush) begin
            // one cycle in WAIT_GNT, the flush, then the kill cycle
            tick();
            flush = 1'b1;
            valid = 1'b0;
            tick();
            flush = 1'b0;
            tick();
        end else begin
            page_offset_matches = (row.hazard_cycles != 0);
            repeat (row.hazard_cycles) tick();
            page_offset_matches = 1'b0;
            accepted = 1'b0;
            while (!accepted) begin
                tick();
            end
            exp_id.push_back(row.trans_id);
            exp_result.push_back(expected_result(row.op, row.vaddr[2:0], row.data));
            valid = 1'b0;
        end
    endtask

    // --------------------------------------
    // main sequence and watchdog
    // --------------------------------------
    initial begin
        flush = 1'b0;
        valid = 1'b0;
        lsu_req = '0;
        dtlb_hit = 1'b1;
        paddr = '0;
        page_offset_matches = 1'b0;
        dcache_rsp = '0;
        {gnt_cnt, gnt_delay, miss_left} = '0;
        {exp_tag, exp_kill, prev_waiting, accepted, tlb_retry} = '0;
        {last_due, cyc, in_flight, max_in_flight, error_count} = '0;
        next_rvalid = 1'b0;
        next_rdata = '0;
        // unwritten words carry a pattern of their own index
        for (int i = 0; i < 2**INDEX_WIDTH; i++) begin
            mem[i] = {4'h5, {5{12'(i)}}};
        end
        build_table();
        table_ready = 1'b1;

        wait (rst_n);
        @(posedge clk);
        #1;
        foreach (rows[r]) begin
            apply_row(rows[r], r);
        end
        while (exp_id.size() > 0) begin
            tick();
        end
        repeat (4) tick();
        check_value("loads in flight after drain", in_flight, 0);
        check_value("peak loads in flight", max_in_flight, META_DEPTH);

        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stop_with_failure("checks reported errors");
        end
    end

    initial begin
        wait (table_ready);
        repeat (rows.size() * 60) @(posedge clk);
        stop_with_failure("timeout: the load sequence did not finish in time");
    end

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
// --------------------------------------
// testbench clock and reset, 4 ns period
// reset is low for the first two rising edges
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    localparam int RESET_CYCLES = 2;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // release the reset shortly after an edge, away from the sampling point
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// File: hw/load_unit_top.sv
// --------------------------------------
// load unit top level
// one request at a time, up to META_DEPTH tagged loads retire in order
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_unit_top (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  logic                                   flush_i,
    // request side
    input  logic                                   valid_i,
    input  load_types_pkg::lsu_req_t               lsu_req_i,
    output logic                                   pop_ld_o,
    // address translation
    output logic                                   translation_req_o,
    output logic [load_cfg_pkg::VLEN-1:0]          vaddr_o,
    input  logic                                   dtlb_hit_i,
    input  logic [load_cfg_pkg::PLEN-1:0]          paddr_i,
    // store hazard check
    output logic [load_cfg_pkg::INDEX_WIDTH-1:0]   page_offset_o,
    input  logic                                   page_offset_matches_i,
    // data cache
    output load_types_pkg::dcache_req_t            dcache_req_o,
    input  load_types_pkg::dcache_rsp_t            dcache_rsp_i,
    // retirement
    output logic                                   valid_o,
    output logic [load_cfg_pkg::TRANS_ID_BITS-1:0] trans_id_o,
    output logic [load_cfg_pkg::XLEN-1:0]          result_o
);

    import load_cfg_pkg::*;
    import load_types_pkg::*;

    logic [INDEX_WIDTH-1:0] index;
    size_e                  size;
    load_meta_t             meta_in, meta_head;
    logic                   fifo_full;

    // the virtual address goes straight to the TLB and the hazard check
    assign vaddr_o       = lsu_req_i.vaddr;
    assign page_offset_o = lsu_req_i.vaddr[INDEX_WIDTH-1:0];

    load_req_decode i_load_req_decode (
        .lsu_req_i (lsu_req_i),
        .index_o   (index),
        .size_o    (size),
        .meta_o    (meta_in)
    );

    load_ctrl_fsm i_load_ctrl_fsm (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .valid_i               (valid_i),
        .flush_i               (flush_i),
        .dtlb_hit_i            (dtlb_hit_i),
        .page_offset_matches_i (page_offset_matches_i),
        .fifo_full_i           (fifo_full),
        .paddr_i               (paddr_i),
        .dcache_rsp_i          (dcache_rsp_i),
        .index_i               (index),
        .size_i                (size),
        .pop_ld_o              (pop_ld_o),
        .translation_req_o     (translation_req_o),
        .dcache_req_o          (dcache_req_o)
    );

    // an accepted request enters the queue, returned data leaves it
    load_meta_fifo i_load_meta_fifo (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .push_i (pop_ld_o),
        .pop_i  (dcache_rsp_i.data_rvalid),
        .meta_i (meta_in),
        .head_o (meta_head),
        .full_o (fifo_full)
    );

    load_result_align i_load_result_align (
        .dcache_rsp_i (dcache_rsp_i),
        .meta_i       (meta_head),
        .valid_o      (valid_o),
        .trans_id_o   (trans_id_o),
        .result_o     (result_o)
    );

endmodule

`default_nettype wire

// File: hw/load_result_align.sv
// --------------------------------------
// result realign and extend
// meta_i must be the queue head of the load whose data is arriving
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_result_align (
    input  load_types_pkg::dcache_rsp_t            dcache_rsp_i,
    input  load_types_pkg::load_meta_t             meta_i,
    output logic                                   valid_o,
    output logic [load_cfg_pkg::TRANS_ID_BITS-1:0] trans_id_o,
    output logic [load_cfg_pkg::XLEN-1:0]          result_o
);

    import load_cfg_pkg::*;
    import load_types_pkg::*;

    logic [XLEN-1:0]   shifted_data;
    logic [XLEN/8-1:0] sign_bits;
    logic              sign_bit;

    // retirement follows the cache directly, with no extra stage
    assign valid_o    = dcache_rsp_i.data_rvalid;
    assign trans_id_o = meta_i.trans_id;

    // move the addressed byte down to bit 0
    assign shifted_data = dcache_rsp_i.data_rdata >> {meta_i.offset, 3'b000};

    // top bit of every byte, picked in parallel with the shifter
    for (genvar i = 0; i < XLEN / 8; i++) begin : gen_sign_bits
        assign sign_bits[i] = dcache_rsp_i.data_rdata[i*8+7];
    end

    // unsigned ops pull the fill to zero
    assign sign_bit = meta_i.is_signed & sign_bits[meta_i.sign_idx];

    // --------------------------------------
    // width select and extension
    // --------------------------------------
    always_comb begin
        unique case (meta_i.op)
            LW, LWU: result_o = {{(XLEN - 32){sign_bit}}, shifted_data[31:0]};
            LH, LHU: result_o = {{(XLEN - 16){sign_bit}}, shifted_data[15:0]};
            LB, LBU: result_o = {{(XLEN - 8){sign_bit}}, shifted_data[7:0]};
            default: result_o = shifted_data;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/load_meta_fifo.sv
// --------------------------------------
// metadata queue for tagged loads waiting on data
// the cache returns data in tag order, so the head is always the next load
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_meta_fifo (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       push_i,
    input  logic                       pop_i,
    input  load_types_pkg::load_meta_t meta_i,
    output load_types_pkg::load_meta_t head_o,
    output logic                       full_o
);

    import load_cfg_pkg::*;
    import load_types_pkg::*;

    load_meta_t               mem_q [META_DEPTH];
    logic [META_PTR_BITS-1:0] wr_ptr_q, rd_ptr_q;
    logic [META_CNT_BITS-1:0] cnt_q;

    // wraps at META_DEPTH so that depths other than powers of two work
    function automatic logic [META_PTR_BITS-1:0] ptr_inc(input logic [META_PTR_BITS-1:0] ptr);
        return (ptr == META_PTR_BITS'(META_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            // count stays put when both happen in one cycle
            if (push_i && !pop_i) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (pop_i && !push_i) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= meta_i;
        end
    end

    assign head_o = mem_q[rd_ptr_q];
    assign full_o = (cnt_q == META_CNT_BITS'(META_DEPTH));

    // the FSM must hold back data_req while full, and the cache must not
    // return data for a load it never got a tag for
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full_o)
        else $error("load accepted while the metadata queue is full");

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> cnt_q != '0)
        else $error("rvalid with no load waiting");

endmodule

`default_nettype wire

// File: hw/load_ctrl_fsm.sv
// --------------------------------------
// load control FSM
// the TLB answers in the request cycle and the cache ignores a kill with
// nothing outstanding
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_ctrl_fsm (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 valid_i,
    input  logic                                 flush_i,
    input  logic                                 dtlb_hit_i,
    input  logic                                 page_offset_matches_i,
    input  logic                                 fifo_full_i,
    input  logic [load_cfg_pkg::PLEN-1:0]        paddr_i,
    input  load_types_pkg::dcache_rsp_t          dcache_rsp_i,
    input  logic [load_cfg_pkg::INDEX_WIDTH-1:0] index_i,
    input  load_types_pkg::size_e                size_i,
    output logic                                 pop_ld_o,
    output logic                                 translation_req_o,
    output load_types_pkg::dcache_req_t          dcache_req_o
);

    import load_cfg_pkg::*;
    import load_types_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GNT,
        SEND_TAG,
        WAIT_PAGE_OFFSET,
        ABORT,
        WAIT_TRANSLATION,
        WAIT_FLUSH
    } load_state_e;

    load_state_e          state_d, state_q;
    logic [TAG_WIDTH-1:0] tag_q;
    logic [ALIGN_BITS:0]  req_end;

    // --------------------------------------
    // next state and cache requests
    // --------------------------------------
    always_comb begin
        state_d                = state_q;
        translation_req_o      = 1'b0;
        dcache_req_o.data_req  = 1'b0;
        dcache_req_o.index     = index_i;
        dcache_req_o.size      = size_i;
        dcache_req_o.tag       = tag_q;
        dcache_req_o.tag_valid = 1'b0;
        dcache_req_o.kill_req  = 1'b0;

        case (state_q)
            // SEND_TAG finishes the previous load and may start the next one
            IDLE, SEND_TAG: begin
                dcache_req_o.tag_valid = (state_q == SEND_TAG);
                state_d = IDLE;
                if (valid_i) begin
                    // translation starts before the hazard is known
                    translation_req_o = 1'b1;
                    if (page_offset_matches_i) begin
                        state_d = WAIT_PAGE_OFFSET;
                    end else begin
                        // a full queue holds the request back without raising it
                        dcache_req_o.data_req = !fifo_full_i;
                        state_d = WAIT_GNT;
                        if (!fifo_full_i && dcache_rsp_i.data_gnt) begin
                            state_d = dtlb_hit_i ? SEND_TAG : ABORT;
                        end
                    end
                end
            end
            // a store with the same page offset is still pending
            WAIT_PAGE_OFFSET: begin
                if (!page_offset_matches_i) begin
                    state_d = WAIT_GNT;
                end
            end
            WAIT_GNT: begin
                translation_req_o     = 1'b1;
                dcache_req_o.data_req = !fifo_full_i;
                if (!fifo_full_i && dcache_rsp_i.data_gnt) begin
                    state_d = dtlb_hit_i ? SEND_TAG : ABORT;
                end
            end
            // the grant came with a TLB miss, so the cache drops the request
            ABORT: begin
                dcache_req_o.tag_valid = 1'b1;
                dcache_req_o.kill_req  = 1'b1;
                state_d = WAIT_TRANSLATION;
            end
            WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = WAIT_GNT;
                end
            end
            // kill whatever untagged request the cache may still hold
            WAIT_FLUSH: begin
                dcache_req_o.tag_valid = 1'b1;
                dcache_req_o.kill_req  = 1'b1;
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        if (flush_i) begin
            state_d = WAIT_FLUSH;
        end

        // the request is taken exactly when a hit grant moves the FSM to SEND_TAG
        pop_ld_o = (state_d == SEND_TAG);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // the tag goes out one cycle after the grant, so capture it at the grant
    always_ff @(posedge clk_i) begin
        if (dcache_req_o.data_req && dcache_rsp_i.data_gnt) begin
            tag_q <= paddr_i[PLEN-1:INDEX_WIDTH];
        end
    end

    // --------------------------------------
    // assertions
    // --------------------------------------
    // end byte of the access, one past the last byte it reads
    assign req_end = {1'b0, index_i[ALIGN_BITS-1:0]} + ((ALIGN_BITS + 1)'(1) << size_i);

    // a live tag always belongs to the grant of the previous cycle
    a_tag_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dcache_req_o.tag_valid && !dcache_req_o.kill_req
        |-> $past(dcache_req_o.data_req && dcache_rsp_i.data_gnt))
        else $error("tag_valid without a grant in the previous cycle");

    a_kill_with_tag: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dcache_req_o.kill_req |-> dcache_req_o.tag_valid)
        else $error("kill_req without tag_valid");

    // misaligned loads are trapped upstream and must never reach this unit
    a_no_word_cross: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_i |-> req_end <= (ALIGN_BITS + 1)'(XLEN / 8))
        else $error("load request crosses a 64-bit word");

endmodule

`default_nettype wire

// File: hw/load_req_decode.sv
// --------------------------------------
// request decode, purely combinational
// the word crossing check sits in the control FSM, which sees valid_i
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_req_decode (
    input  load_types_pkg::lsu_req_t                lsu_req_i,
    output logic [load_cfg_pkg::INDEX_WIDTH-1:0]    index_o,
    output load_types_pkg::size_e                   size_o,
    output load_types_pkg::load_meta_t              meta_o
);

    import load_cfg_pkg::*;
    import load_types_pkg::*;

    // byte count of the access minus one
    logic [ALIGN_BITS-1:0] width_m1;
    logic [ALIGN_BITS-1:0] offset;

    // the page offset goes to the cache as the index before translation ends
    assign index_o = lsu_req_i.vaddr[INDEX_WIDTH-1:0];
    assign offset  = lsu_req_i.vaddr[ALIGN_BITS-1:0];

    // --------------------------------------
    // op to size
    // --------------------------------------
    always_comb begin
        case (lsu_req_i.op)
            LB, LBU: begin
                size_o   = BYTE;
                width_m1 = ALIGN_BITS'(0);
            end
            LH, LHU: begin
                size_o   = HALF;
                width_m1 = ALIGN_BITS'(1);
            end
            LW, LWU: begin
                size_o   = WORD;
                width_m1 = ALIGN_BITS'(3);
            end
            default: begin
                size_o   = DOUBLE;
                width_m1 = ALIGN_BITS'(7);
            end
        endcase
    end

    // --------------------------------------
    // retire metadata
    // --------------------------------------
    always_comb begin
        meta_o.trans_id  = lsu_req_i.trans_id;
        meta_o.offset    = offset;
        meta_o.op        = lsu_req_i.op;
        // LD fills all 64 bits, so it never needs a sign
        meta_o.is_signed = lsu_req_i.op inside {LB, LH, LW};
        // the byte that holds the sign bit is known before the data arrives,
        // which keeps the sign select off the shifter path
        meta_o.sign_idx  = offset + width_m1;
    end

endmodule

`default_nettype wire

// File: hw/load_types_pkg.sv
// --------------------------------------
// types that travel between the load unit blocks and the data cache
// only the integer loads are encoded and the cache port is read only
// --------------------------------------
`default_nettype none

package load_types_pkg;

    import load_cfg_pkg::*;

    // integer load opcodes
    typedef enum logic [2:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        LWU,
        LD
    } load_op_e;

    // transfer size as the cache sees it, log2 of the byte count
    typedef enum logic [1:0] {
        BYTE   = 2'd0,
        HALF   = 2'd1,
        WORD   = 2'd2,
        DOUBLE = 2'd3
    } size_e;

    // one load request from the issue side
    typedef struct packed {
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [VLEN-1:0]          vaddr;
        load_op_e                 op;
    } lsu_req_t;

    // everything the result path needs once the data comes back
    typedef struct packed {
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [ALIGN_BITS-1:0]    offset;
        load_op_e                 op;
        logic                     is_signed;
        logic [ALIGN_BITS-1:0]    sign_idx;
    } load_meta_t;

    // load unit to data cache
    typedef struct packed {
        logic                   data_req;
        logic [INDEX_WIDTH-1:0] index;
        size_e                  size;
        logic [TAG_WIDTH-1:0]   tag;
        logic                   tag_valid;
        logic                   kill_req;
    } dcache_req_t;

    // data cache to load unit
    typedef struct packed {
        logic            data_gnt;
        logic            data_rvalid;
        logic [XLEN-1:0] data_rdata;
    } dcache_rsp_t;

endpackage

`default_nettype wire

// File: hw/load_cfg_pkg.sv
// --------------------------------------
// widths and depths of the load unit
// the cache index doubles as the page offset, so INDEX_WIDTH stays at 12
// --------------------------------------
`default_nettype none

package load_cfg_pkg;

    // data path width and the byte offset inside one data word
    localparam int unsigned XLEN = 64;
    localparam int unsigned ALIGN_BITS = 3;

    // virtual and physical address widths of the Sv39 data path
    localparam int unsigned VLEN = 39;
    localparam int unsigned PLEN = 56;

    // cache address split
    localparam int unsigned INDEX_WIDTH = 12;
    localparam int unsigned TAG_WIDTH = PLEN - INDEX_WIDTH;

    // width of the transaction id handed back at retirement
    localparam int unsigned TRANS_ID_BITS = 3;

    // number of tagged loads that may wait for their data
    localparam int unsigned META_DEPTH = 2;
    localparam int unsigned META_PTR_BITS = (META_DEPTH > 1) ? $clog2(META_DEPTH) : 1;
    localparam int unsigned META_CNT_BITS = $clog2(META_DEPTH + 1);

endpackage

`default_nettype wire
